/* build.f */
hw/acq_pkg.sv
hw/adc_sequencer.sv
hw/frame_dispatcher.sv
hw/link_controller.sv
hw/serial_transmitter.sv
hw/acq_top.sv
testbench/acq_props.sv
testbench/acq_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the acquisition testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module acq_tb -Mdir obj_dir -o acq_sim -f build.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/acq_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation FAILED" "$log"; then
	exit 1
fi
if ! grep -q "Simulation PASSED" "$log"; then
	echo "no result line in $log"
	exit 1
fi
exit 0

/* testbench/acq_tb.sv */
//////////////////////////////////////////////////////////////////////
// testbench for the acquisition and serial reporting subsystem
// clock, reset, ADC model, random dsr stalls, serial decoder,
// expected byte model, checks, watchdog and result line
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module acq_tb;
	import acq_pkg::*;

	localparam int num_channels = 5;
	localparam int bit_cycles = 8;
	localparam int num_samples = 30;
	// nominal length of the run in cycles, margin covers dsr stalls
	localparam int run_cycles = num_samples * (2 * 10 * bit_cycles + 100);
	localparam int timeout_cycles = 2 * run_cycles + 1000;

	logic clock;
	logic rst;
	logic eoc;
	sample_t adc_data;
	logic dsr;
	logic mux_en;
	channel_t canale;
	logic soc;
	logic load_dato;
	logic add_mpx2;
	logic error;
	logic data_out;

	logic [31:0] rng;
	int errors;
	int rx_count;
	int stall_cycles;
	sample_t last_data;
	// header and data bytes in line order
	sample_t expected[$];
	channel_t exp_ch;

	acq_top #(
		.num_channels(num_channels),
		.bit_cycles(bit_cycles)
	) dut0 (
		.clock(clock),
		.rst(rst),
		.eoc(eoc),
		.adc_data(adc_data),
		.dsr(dsr),
		.mux_en(mux_en),
		.canale(canale),
		.soc(soc),
		.load_dato(load_dato),
		.add_mpx2(add_mpx2),
		.error(error),
		.data_out(data_out)
	);

	always #50 clock = ~clock;

	function automatic logic [31:0] next_random();
		rng = rng * 32'd1664525 + 32'd1013904223;
		return rng;
	endfunction

	function automatic int random_range(input int lo, input int hi);
		logic [31:0] r;
		r = next_random();
		return lo + int'(r[31:16] % 16'(hi - lo + 1));
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic note_failure(input string msg);
		errors++;
		$display("failure at %0t: %s", $time, msg);
	endtask

	initial begin
		rng = 32'h26aa_a383;
		errors = 0;
		rx_count = 0;
		stall_cycles = 0;
		exp_ch = '0;
		last_data = '0;
		clock = 1'b0;
		rst = 1'b1;
		eoc = 1'b0;
		adc_data = '0;
		dsr = 1'b1;
		repeat (10) @(posedge clock);
		#1 rst = 1'b0;
		// outputs idle after reset, before the first mux_en
		@(negedge clock);
		check_value("soc", 32'(soc), 32'd0);
		check_value("load_dato", 32'(load_dato), 32'd0);
		check_value("mux_en", 32'(mux_en), 32'd0);
		check_value("error", 32'(error), 32'd0);
		check_value("canale", 32'(canale), 32'd0);
		check_value("data_out", 32'(data_out), 32'd1);
		wait (rx_count >= 2 * num_samples);
		repeat (4) @(posedge clock);
		if (stall_cycles == 0)
			note_failure("dsr never held back a pending frame");
		$display("errors: %0d, bytes received: %0d of %0d, error-flag cycles: %0d",
			errors, rx_count, 2 * num_samples, stall_cycles);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// converter: eoc with fresh data some cycles after soc, dropped after soc falls
	initial begin : adc_model
		int delay;
		forever begin
			@(negedge clock);
			if (!rst && soc && !eoc) begin
				delay = random_range(1, 20);
				last_data = sample_t'(next_random() >> 24);
				repeat (delay) @(posedge clock);
				#1;
				eoc = 1'b1;
				adc_data = last_data;
				@(negedge clock);
				while (soc)
					@(negedge clock);
				@(posedge clock);
				#1;
				eoc = 1'b0;
				// garbage on the bus outside eoc
				adc_data = ~last_data;
			end
		end
	end

	// receiver readiness, random low windows
	initial begin : dsr_model
		int high_len;
		int low_len;
		@(negedge rst);
		forever begin
			high_len = random_range(40, 200);
			low_len = random_range(0, 60);
			repeat (high_len) @(posedge clock);
			#1 dsr = 1'b0;
			repeat (low_len) @(posedge clock);
			#1 dsr = 1'b1;
		end
	end

	// channel order, expected bytes and error flag, sampled mid-cycle
	initial begin : output_monitor
		logic prev_soc;
		prev_soc = 1'b0;
		forever begin
			@(negedge clock);
			if (!rst) begin
				if (soc && !prev_soc && !mux_en)
					note_failure("soc rose while mux_en was low");
				if (load_dato) begin
					check_value("canale", 32'(canale), 32'(exp_ch));
					expected.push_back({4'b0000, exp_ch});
					expected.push_back(last_data);
					exp_ch = (exp_ch == channel_t'(num_channels - 1)) ? '0 : exp_ch + 1'b1;
				end
				if (error) begin
					stall_cycles++;
					if (dsr)
						note_failure("error flag high while dsr is high");
				end
			end
			prev_soc = soc;
		end
	end

	// frame decoder, every cycle of a bit must match its first cycle
	initial begin : serial_decoder
		logic idle_dsr;
		logic first;
		logic value;
		logic exp_sel;
		sample_t byte_val;
		idle_dsr = 1'b1;
		forever begin
			@(negedge clock);
			if (!rst && !data_out) begin
				// go was decided with the dsr of the previous cycle
				if (!idle_dsr)
					note_failure("start bit began while dsr was low");
				exp_sel = rx_count[0];
				byte_val = '0;
				first = 1'b0;
				value = 1'b0;
				for (int b = 0; b < 10; b++) begin
					for (int c = 0; c < bit_cycles; c++) begin
						if (b != 0 || c != 0)
							@(negedge clock);
						if (c == 0)
							first = data_out;
						else if (data_out !== first)
							note_failure($sformatf("bit %0d of frame %0d not %0d cycles wide",
								b, rx_count, bit_cycles));
						if (c == bit_cycles / 2) begin
							value = data_out;
							check_value("add_mpx2", 32'(add_mpx2), 32'(exp_sel));
						end
					end
					if (b == 0)
						check_value("data_out start bit", 32'(value), 32'd0);
					else if (b == 9)
						check_value("data_out stop bit", 32'(value), 32'd1);
					else
						byte_val = {byte_val[6:0], value};
				end
				if (expected.size() == 0)
					note_failure("frame on the line with no sample latched for it");
				else
					check_value("data_out byte", 32'(byte_val), 32'(expected.pop_front()));
				rx_count++;
			end
			idle_dsr = dsr;
		end
	end

	initial begin : watchdog
		repeat (timeout_cycles) @(posedge clock);
		$display("timeout after %0d cycles, errors: %0d, bytes received: %0d of %0d",
			timeout_cycles, errors, rx_count, 2 * num_samples);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/acq_props.sv */
//////////////////////////////////////////////////////////////////////
// protocol assertions for the acquisition top level
// load / send exclusion, soc around load_dato,
// idle line between frames, error only while stalled on dsr
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module acq_props (
	input logic clock,
	input logic rst,
	input logic load,
	input logic send,
	input logic soc,
	input logic load_dato,
	input logic data_out,
	input logic tx_busy,
	input logic error,
	input logic dsr
);

	// load and send are consecutive pulses, never the same cycle
	load_send_apart: assert property (@(posedge clock) disable iff (rst) !(load && send))
		else $error("load and send asserted in the same cycle");

	// sample is latched while the conversion request is still up
	latch_under_soc: assert property (@(posedge clock) disable iff (rst) load_dato |-> soc)
		else $error("load_dato without soc");

	// mark level whenever the transmitter is not shifting
	idle_line_high: assert property (@(posedge clock) disable iff (rst) !tx_busy |-> data_out)
		else $error("data_out low with no frame in progress");

	// a held-back frame has not started shifting yet
	error_needs_dsr_low: assert property (@(posedge clock) disable iff (rst)
		error |-> !dsr && !tx_busy)
		else $error("error high while dsr is high or a frame is in progress");

endmodule

bind acq_top acq_props props0 (
	.clock(clock),
	.rst(rst),
	.load(load),
	.send(send),
	.soc(soc),
	.load_dato(load_dato),
	.data_out(data_out),
	.tx_busy(tx0.busy),
	.error(error),
	.dsr(dsr)
);

`default_nettype wire

/* hw/acq_top.sv */
//////////////////////////////////////////////////////////////////////
// acquisition and serial reporting top level
// sequencer -> dispatcher -> link controller -> transmitter
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module acq_top #(
	parameter int num_channels = 8,
	parameter int settle_cycles = 2,
	parameter int bit_cycles = 104
) (
	input logic clock,
	input logic rst,
	input logic eoc,
	input acq_pkg::sample_t adc_data,
	input logic dsr,
	output logic mux_en,
	output acq_pkg::channel_t canale,
	output logic soc,
	output logic load_dato,
	output logic add_mpx2,
	output logic error,
	output logic data_out
);
	import acq_pkg::*;

	// sequencer to dispatcher
	logic send_req;
	logic send_done;
	sample_t sample;

	// dispatcher to link controller
	sample_t frame_byte;
	logic shot;
	logic confirm;

	// link controller to transmitter
	logic load;
	logic send;
	logic tx_end;

	adc_sequencer #(
		.num_channels(num_channels),
		.settle_cycles(settle_cycles)
	) seq0 (
		.clock(clock),
		.rst(rst),
		.eoc(eoc),
		.adc_data(adc_data),
		.mux_en(mux_en),
		.canale(canale),
		.soc(soc),
		.load_dato(load_dato),
		.send_req(send_req),
		.sample(sample),
		.send_done(send_done)
	);

	frame_dispatcher disp0 (
		.clock(clock),
		.rst(rst),
		.send_req(send_req),
		.sample(sample),
		.canale(canale),
		.send_done(send_done),
		.add_mpx2(add_mpx2),
		.frame_byte(frame_byte),
		.shot(shot),
		.confirm(confirm)
	);

	link_controller link0 (
		.clock(clock),
		.rst(rst),
		.shot(shot),
		.load(load),
		.send(send),
		.tx_end(tx_end),
		.confirm(confirm)
	);

	serial_transmitter #(
		.bit_cycles(bit_cycles)
	) tx0 (
		.clock(clock),
		.rst(rst),
		.load(load),
		.send(send),
		.frame_byte(frame_byte),
		.dsr(dsr),
		.tx_end(tx_end),
		.error(error),
		.data_out(data_out)
	);

endmodule

`default_nettype wire

/* hw/serial_transmitter.sv */
//////////////////////////////////////////////////////////////////////
// asynchronous serial transmitter
// holding register and pending flag, dsr gating and error flag,
// bit-period divider, start / 8 data msb first / stop shift-out
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module serial_transmitter #(
	parameter int bit_cycles = 104
) (
	input logic clock,
	input logic rst,
	input logic load,
	input logic send,
	input acq_pkg::sample_t frame_byte,
	input logic dsr,
	output logic tx_end,
	output logic error,
	output logic data_out
);
	import acq_pkg::*;

	localparam bit_count_t bit_last = bit_count_t'(bit_cycles - 1);

	sample_t tx_reg;
	// data bits msb first, stop bit in the lsb
	logic [8:0] shift_reg;
	// frame loaded but not yet started
	logic held;
	// send seen, start waits on dsr
	logic armed;
	logic busy;
	logic go;
	bit_count_t bit_cnt;
	// 0 start, 1..8 data, 9 stop
	logic [3:0] bit_idx;

	// dsr only matters before the start bit
	assign go = held && (armed || send) && dsr && !busy;

	// frame held back by the receiver
	assign error = held && !dsr;

	// last cycle of the stop bit
	assign tx_end = busy && (bit_idx == 4'd9) && (bit_cnt == bit_last);

	always_ff @(posedge clock) begin
		if (rst) begin
			held <= 1'b0;
			armed <= 1'b0;
			busy <= 1'b0;
			data_out <= 1'b1;
			bit_cnt <= '0;
			bit_idx <= '0;
		end else if (busy) begin
			if (bit_cnt == bit_last) begin
				bit_cnt <= '0;
				if (bit_idx == 4'd9) begin
					// back to idle mark
					busy <= 1'b0;
					data_out <= 1'b1;
				end else begin
					data_out <= shift_reg[8];
					bit_idx <= bit_idx + 1'b1;
				end
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end else begin
			if (load)
				held <= 1'b1;
			if (go) begin
				// start bit goes out right away
				held <= 1'b0;
				armed <= 1'b0;
				busy <= 1'b1;
				data_out <= 1'b0;
				bit_cnt <= '0;
				bit_idx <= '0;
			end else if (send) begin
				armed <= 1'b1;
			end
		end
	end

	// payload registers
	always_ff @(posedge clock) begin
		if (load)
			tx_reg <= frame_byte;
		if (go)
			shift_reg <= {tx_reg, 1'b1};
		else if (busy && bit_cnt == bit_last)
			shift_reg <= {shift_reg[7:0], 1'b1};
	end

endmodule

`default_nettype wire

/* hw/link_controller.sv */
//////////////////////////////////////////////////////////////////////
// link controller
// per-frame handshake: shot -> load -> send -> wait tx_end -> confirm
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module link_controller (
	input logic clock,
	input logic rst,
	input logic shot,
	output logic load,
	output logic send,
	input logic tx_end,
	output logic confirm
);
	import acq_pkg::*;

	link_state_t state;

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= link_idle;
			load <= 1'b0;
			send <= 1'b0;
			confirm <= 1'b0;
		end else begin
			// all three outputs are one-cycle pulses
			load <= 1'b0;
			send <= 1'b0;
			confirm <= 1'b0;
			case (state)
				link_idle: begin
					if (shot) begin
						load <= 1'b1;
						state <= link_load;
					end
				end
				link_load: begin
					// byte is in the holding register now
					send <= 1'b1;
					state <= link_send;
				end
				link_send: begin
					state <= link_wait_end;
				end
				link_wait_end: begin
					// dsr stalls show up here as a long wait
					if (tx_end) begin
						confirm <= 1'b1;
						state <= link_idle;
					end
				end
				default: state <= link_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/frame_dispatcher.sv */
//////////////////////////////////////////////////////////////////////
// frame dispatcher
// splits one latched sample into a header frame (channel number)
// and a data frame (sample), fired one after the other
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module frame_dispatcher (
	input logic clock,
	input logic rst,
	input logic send_req,
	input acq_pkg::sample_t sample,
	input acq_pkg::channel_t canale,
	output logic send_done,
	output logic add_mpx2,
	output acq_pkg::sample_t frame_byte,
	output logic shot,
	input logic confirm
);
	import acq_pkg::*;

	disp_state_t state;

	// header byte carries the channel in its low nibble
	assign frame_byte = add_mpx2 ? sample : {4'b0000, canale};

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= disp_idle;
			shot <= 1'b0;
			send_done <= 1'b0;
			add_mpx2 <= 1'b0;
		end else begin
			// shot and send_done are single-cycle strobes
			shot <= 1'b0;
			send_done <= 1'b0;
			case (state)
				disp_idle: begin
					if (send_req) begin
						add_mpx2 <= 1'b0;
						shot <= 1'b1;
						state <= disp_header;
					end
				end
				disp_header: begin
					// switch to data byte once header is on the wire
					if (confirm) begin
						add_mpx2 <= 1'b1;
						shot <= 1'b1;
						state <= disp_data;
					end
				end
				disp_data: begin
					if (confirm) begin
						send_done <= 1'b1;
						state <= disp_done;
					end
				end
				disp_done: begin
					// let the sequencer drop send_req before rearming
					add_mpx2 <= 1'b0;
					state <= disp_idle;
				end
				default: state <= disp_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/adc_sequencer.sv */
//////////////////////////////////////////////////////////////////////
// channel-stepping conversion controller
// drives the analog mux enable and channel, ADC start of conversion,
// latches the sample on end of conversion and holds the send request
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module adc_sequencer #(
	parameter int num_channels = 8,
	parameter int settle_cycles = 2
) (
	input logic clock,
	input logic rst,
	input logic eoc,
	input acq_pkg::sample_t adc_data,
	output logic mux_en,
	output acq_pkg::channel_t canale,
	output logic soc,
	output logic load_dato,
	output logic send_req,
	output acq_pkg::sample_t sample,
	input logic send_done
);
	import acq_pkg::*;

	// counter must reach settle_cycles itself
	localparam int settle_w = $clog2(settle_cycles + 1);
	localparam logic [settle_w-1:0] settle_last = settle_w'(settle_cycles);
	localparam channel_t last_channel = channel_t'(num_channels - 1);

	seq_state_t state;
	logic [settle_w-1:0] settle_cnt;

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= seq_mux_settle;
			mux_en <= 1'b0;
			soc <= 1'b0;
			load_dato <= 1'b0;
			send_req <= 1'b0;
			canale <= '0;
			settle_cnt <= '0;
		end else begin
			case (state)
				seq_mux_settle: begin
					// cnt is the number of cycles since mux_en went high
					mux_en <= 1'b1;
					settle_cnt <= settle_cnt + 1'b1;
					if (settle_cnt == settle_last) begin
						soc <= 1'b1;
						state <= seq_start_conv;
					end
				end
				seq_start_conv: begin
					// one cycle for soc to reach the converter
					state <= seq_wait_eoc;
				end
				seq_wait_eoc: begin
					// soc stays up until eoc is seen
					if (eoc) begin
						load_dato <= 1'b1;
						state <= seq_latch;
					end
				end
				seq_latch: begin
					load_dato <= 1'b0;
					soc <= 1'b0;
					mux_en <= 1'b0;
					send_req <= 1'b1;
					state <= seq_wait_sent;
				end
				seq_wait_sent: begin
					// channel and sample frozen until both frames are out
					if (send_done) begin
						send_req <= 1'b0;
						mux_en <= 1'b1;
						settle_cnt <= settle_w'(1);
						canale <= (canale == last_channel) ? '0 : canale + 1'b1;
						state <= seq_mux_settle;
					end
				end
				default: state <= seq_mux_settle;
			endcase
		end
	end

	// sample register, data valid while eoc is high
	always_ff @(posedge clock) begin
		if (state == seq_wait_eoc && eoc)
			sample <= adc_data;
	end

endmodule

`default_nettype wire

/* hw/acq_pkg.sv */
//////////////////////////////////////////////////////////////////////
// shared types for the acquisition and serial reporting subsystem
// sample, channel and bit-period count vectors
// state encodings of the sequencer, dispatcher and link FSMs
//////////////////////////////////////////////////////////////////////
`default_nettype none

package acq_pkg;

	// one ADC sample, also one byte on the serial line
	typedef logic [7:0] sample_t;

	// analog mux channel, low nibble of the header byte
	typedef logic [3:0] channel_t;

	// clock cycles inside one serial bit period
	typedef logic [9:0] bit_count_t;

	// conversion sequencer
	typedef enum logic [2:0] {
		seq_mux_settle,
		seq_start_conv,
		seq_wait_eoc,
		seq_latch,
		seq_wait_sent
	} seq_state_t;

	// header then data frame per sample
	typedef enum logic [1:0] {
		disp_idle,
		disp_header,
		disp_data,
		disp_done
	} disp_state_t;

	// load / send / wait-for-end toward the transmitter
	typedef enum logic [1:0] {
		link_idle,
		link_load,
		link_send,
		link_wait_end
	} link_state_t;

endpackage

`default_nettype wire
